/* Bender.yml */
package:
  name: dram_command

sources:
  - include_dirs:
      - common
    files:
      - common/dram_state_pkg.sv
      - common/dram_cmd_pkg.sv
      - dram_command/dram_timer.sv
      - dram_command/dram_fsm.sv
      - dram_command/dram_cmd_encoder.sv
      - dram_command/dram_command.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/dram_command_properties.sv
      - verification/tb_dram_command.sv

/* common/dram_cmd_pkg.sv */
/*
 * DDR4 command pin bundle width
 * command opcodes as {cs_n, act_n, ras_n_a16, cas_n_a15, we_n_a14}
 */
package dram_cmd_pkg;

    parameter int CMD_W = 5;

    typedef enum logic [CMD_W-1:0] {
        // chip not selected
        DESEL_CMD     = 5'b11111,
        // cs_n high, command pins held low while the device powers up
        POWER_UP_PRG  = 5'b10000,
        // mode register set
        LOAD_MODE_CMD = 5'b01000,
        ZQ_CMD        = 5'b01110,
        // low three bits carry row bits 16..14 on the pins
        ACTIVATE_CMD  = 5'b00000,
        WRITE_CMD     = 5'b01100,
        READ_CMD      = 5'b01101,
        PRECHARGE_CMD = 5'b01010
    } cmd_t;

endpackage

/* common/dram_macros.svh */
/*
 * shared widths for the sequencer ports and counter
 * small simulation timing values, in clock cycles
 * mode register load table (bank group, bank, address)
 * address for the ZQ calibration command
 */
`ifndef DRAM_MACROS_SVH
`define DRAM_MACROS_SVH

// widths
`define DRAM_CNT_W  12
`define DRAM_ROW_W  17
`define DRAM_COL_W  10
`define DRAM_ADDR_W 14
`define DRAM_BG_W   2
`define DRAM_BA_W   2

// init timings, shortened for simulation
`define T_PWUP   12'd10
`define T_PDXPR  12'd8
`define T_DLLK   12'd12
`define T_MOD    12'd4
`define T_ZQINIT 12'd16

// request timings
`define T_RCD    12'd3
`define T_CAS    12'd4
`define T_BURST  12'd4
`define T_WL     12'd3
`define T_WR     12'd4
`define T_RP     12'd3

// first load, enables the DLL through MR1
`define MR_DLL_BG   2'h0
`define MR_DLL_BA   2'h1
`define MR_DLL_ADDR 14'h0001

// remaining loads, in issue order
`define MR3_BG   2'h0
`define MR3_BA   2'h3
`define MR3_ADDR 14'h0000
`define MR6_BG   2'h1
`define MR6_BA   2'h2
`define MR6_ADDR 14'h080F
`define MR5_BG   2'h1
`define MR5_BA   2'h1
`define MR5_ADDR 14'h0000
`define MR4_BG   2'h1
`define MR4_BA   2'h0
`define MR4_ADDR 14'h1000
`define MR2_BG   2'h0
`define MR2_BA   2'h2
`define MR2_ADDR 14'h0088
`define MR1_BG   2'h0
`define MR1_BA   2'h1
`define MR1_ADDR 14'h0001
`define MR0_BG   2'h0
`define MR0_BA   2'h0
`define MR0_ADDR 14'h041D

// ZQCL long calibration, A10 high
`define ZQ_ADDR 14'h0400

`endif

/* common/dram_state_pkg.sv */
/*
 * sequencer state type
 * init chain first, then the request loop
 */
package dram_state_pkg;

    typedef enum logic [4:0] {
        // power-up and reset release
        POWER_UP,
        PRE_RESET,
        RESET,
        NOP,
        // mode register loads, DLL first
        LOAD_MODE_DLL,
        LOAD_BG0_REG3,
        LOAD_BG1_REG6,
        LOAD_BG1_REG5,
        LOAD_BG1_REG4,
        LOAD_BG0_REG2,
        LOAD_BG0_REG1,
        LOAD_BG0_REG0,
        ZQ_CL,
        // request loop
        IDLE,
        ACTIVATE,
        WRITE_COMMAND,
        READ_COMMAND,
        PRECHARGE
    } dram_state_t;

endpackage

/* dram_command/dram_cmd_encoder.sv */
/*
 * command pin encoding from state and timing count
 * mode register table, bank and address muxing
 * power, reset and clock-enable levels through init
 * data window enables and the request done pulse
 */
`timescale 1ns/1ps
`include "dram_macros.svh"

module dram_cmd_encoder
    import dram_state_pkg::*;
    import dram_cmd_pkg::*;
(
    input  dram_state_t             state,
    input  logic [`DRAM_CNT_W-1:0]  timing_count,
    input  logic                    expired,
    input  logic [`DRAM_BG_W-1:0]   bg,
    input  logic [`DRAM_BA_W-1:0]   ba,
    input  logic [`DRAM_ROW_W-1:0]  row,
    input  logic [`DRAM_COL_W-1:0]  col,
    output logic                    cs_n,
    output logic                    act_n,
    output logic                    ras_n_a16,
    output logic                    cas_n_a15,
    output logic                    we_n_a14,
    output logic [`DRAM_BG_W-1:0]   ram_bg,
    output logic [`DRAM_BA_W-1:0]   ram_ba,
    output logic [`DRAM_ADDR_W-1:0] ram_addr,
    output logic                    cke,
    output logic                    reset_n,
    output logic                    pwr,
    output logic                    vref,
    output logic                    wr_en,
    output logic                    rd_en,
    output logic                    request_done
);

    cmd_t             cmd;
    logic [CMD_W-1:0] cmd_pins;
    logic             issue;
    logic [`DRAM_ADDR_W-1:0] col_addr;

    // commands go out on the first cycle of a state only
    assign issue = (timing_count == 1);

    // A13 low, A12 high for no burst chop, A11 low, A10 low for no auto-precharge
    assign col_addr = {1'b0, 1'b1, 1'b0, 1'b0, col};

    always_comb begin
        cmd      = DESEL_CMD;
        ram_bg   = '0;
        ram_ba   = '0;
        ram_addr = '0;
        case (state)
            POWER_UP, PRE_RESET, RESET: if (issue) cmd = POWER_UP_PRG;
            LOAD_MODE_DLL: begin
                if (issue) begin
                    cmd      = LOAD_MODE_CMD;
                    ram_bg   = `MR_DLL_BG;
                    ram_ba   = `MR_DLL_BA;
                    ram_addr = `MR_DLL_ADDR;
                end
            end
            LOAD_BG0_REG3: begin
                if (issue) begin
                    cmd      = LOAD_MODE_CMD;
                    ram_bg   = `MR3_BG;
                    ram_ba   = `MR3_BA;
                    ram_addr = `MR3_ADDR;
                end
            end
            LOAD_BG1_REG6: begin
                if (issue) begin
                    cmd      = LOAD_MODE_CMD;
                    ram_bg   = `MR6_BG;
                    ram_ba   = `MR6_BA;
                    ram_addr = `MR6_ADDR;
                end
            end
            LOAD_BG1_REG5: begin
                if (issue) begin
                    cmd      = LOAD_MODE_CMD;
                    ram_bg   = `MR5_BG;
                    ram_ba   = `MR5_BA;
                    ram_addr = `MR5_ADDR;
                end
            end
            LOAD_BG1_REG4: begin
                if (issue) begin
                    cmd      = LOAD_MODE_CMD;
                    ram_bg   = `MR4_BG;
                    ram_ba   = `MR4_BA;
                    ram_addr = `MR4_ADDR;
                end
            end
            LOAD_BG0_REG2: begin
                if (issue) begin
                    cmd      = LOAD_MODE_CMD;
                    ram_bg   = `MR2_BG;
                    ram_ba   = `MR2_BA;
                    ram_addr = `MR2_ADDR;
                end
            end
            LOAD_BG0_REG1: begin
                if (issue) begin
                    cmd      = LOAD_MODE_CMD;
                    ram_bg   = `MR1_BG;
                    ram_ba   = `MR1_BA;
                    ram_addr = `MR1_ADDR;
                end
            end
            LOAD_BG0_REG0: begin
                if (issue) begin
                    cmd      = LOAD_MODE_CMD;
                    ram_bg   = `MR0_BG;
                    ram_ba   = `MR0_BA;
                    ram_addr = `MR0_ADDR;
                end
            end
            ZQ_CL: begin
                if (issue) begin
                    cmd      = ZQ_CMD;
                    ram_addr = `ZQ_ADDR;
                end
            end
            ACTIVATE: begin
                if (issue) begin
                    cmd      = ACTIVATE_CMD;
                    ram_bg   = bg;
                    ram_ba   = ba;
                    ram_addr = row[`DRAM_ADDR_W-1:0];
                end
            end
            // bank and column stay on the bus for the whole burst
            WRITE_COMMAND, READ_COMMAND: begin
                if (issue) begin
                    cmd = (state == WRITE_COMMAND) ? WRITE_CMD : READ_CMD;
                end
                ram_bg   = bg;
                ram_ba   = ba;
                ram_addr = col_addr;
            end
            // single bank precharge, A10 stays low
            PRECHARGE: begin
                if (issue) begin
                    cmd    = PRECHARGE_CMD;
                    ram_bg = bg;
                    ram_ba = ba;
                end
            end
            default: cmd = DESEL_CMD;
        endcase
    end

    // activate shares ras/cas/we with row bits 16..14
    always_comb begin
        cmd_pins = cmd;
        if (state == ACTIVATE && issue) begin
            cmd_pins[2:0] = row[`DRAM_ROW_W-1:`DRAM_ADDR_W];
        end
    end

    assign {cs_n, act_n, ras_n_a16, cas_n_a15, we_n_a14} = cmd_pins;

    // supply, reset and clock enable ramp
    always_comb begin
        cke     = 1'b1;
        reset_n = 1'b1;
        pwr     = 1'b1;
        vref    = 1'b1;
        case (state)
            POWER_UP: begin
                cke     = 1'b0;
                reset_n = 1'b0;
                pwr     = 1'b0;
                vref    = 1'b0;
            end
            PRE_RESET: begin
                cke     = 1'b0;
                reset_n = 1'b0;
            end
            // reset released, clock still disabled
            RESET:   cke = 1'b0;
            default: cke = 1'b1;
        endcase
    end

    // data windows, counted from the column command
    assign wr_en = (state == WRITE_COMMAND)
                && (timing_count > `T_WL)
                && (timing_count <= `T_WL + `T_BURST);
    assign rd_en = (state == READ_COMMAND)
                && (timing_count > `T_CAS)
                && (timing_count <= `T_CAS + `T_BURST);

    // last cycle of the column state
    assign request_done = expired && (state == WRITE_COMMAND || state == READ_COMMAND);

endmodule

/* dram_command/dram_command.sv */
/*
 * DDR4 command sequencer top level
 * timer, state machine and pin encoder
 */
`timescale 1ns/1ps
`include "dram_macros.svh"

module dram_command
    import dram_state_pkg::*;
(
    input  logic                    CLK,
    input  logic                    nRST,
    // scheduler side
    input  logic                    wr_req,
    input  logic                    rd_req,
    input  logic [`DRAM_BG_W-1:0]   bg,
    input  logic [`DRAM_BA_W-1:0]   ba,
    input  logic [`DRAM_ROW_W-1:0]  row,
    input  logic [`DRAM_COL_W-1:0]  col,
    output logic                    request_done,
    output logic                    wr_en,
    output logic                    rd_en,
    // RAM side
    output logic                    cs_n,
    output logic                    act_n,
    output logic                    ras_n_a16,
    output logic                    cas_n_a15,
    output logic                    we_n_a14,
    output logic [`DRAM_BG_W-1:0]   ram_bg,
    output logic [`DRAM_BA_W-1:0]   ram_ba,
    output logic [`DRAM_ADDR_W-1:0] ram_addr,
    output logic                    cke,
    output logic                    reset_n,
    output logic                    pwr,
    output logic                    vref
);

    dram_state_t            state;
    logic [`DRAM_CNT_W-1:0] timing_count;
    logic                   expired;

    dram_timer i_timer (
        .CLK          (CLK),
        .nRST         (nRST),
        .state        (state),
        .timing_count (timing_count),
        .expired      (expired)
    );

    dram_fsm i_fsm (
        .CLK     (CLK),
        .nRST    (nRST),
        .expired (expired),
        .wr_req  (wr_req),
        .rd_req  (rd_req),
        .state   (state)
    );

    dram_cmd_encoder i_encoder (
        .state        (state),
        .timing_count (timing_count),
        .expired      (expired),
        .bg           (bg),
        .ba           (ba),
        .row          (row),
        .col          (col),
        .cs_n         (cs_n),
        .act_n        (act_n),
        .ras_n_a16    (ras_n_a16),
        .cas_n_a15    (cas_n_a15),
        .we_n_a14     (we_n_a14),
        .ram_bg       (ram_bg),
        .ram_ba       (ram_ba),
        .ram_addr     (ram_addr),
        .cke          (cke),
        .reset_n      (reset_n),
        .pwr          (pwr),
        .vref         (vref),
        .wr_en        (wr_en),
        .rd_en        (rd_en),
        .request_done (request_done)
    );

endmodule

/* dram_command/dram_fsm.sv */
/*
 * sequencer state register and next-state logic
 * init chain stepped on each expiry, ending in IDLE
 * one request at a time through ACTIVATE, READ or WRITE and PRECHARGE
 */
`timescale 1ns/1ps

module dram_fsm
    import dram_state_pkg::*;
(
    input  logic        CLK,
    input  logic        nRST,
    input  logic        expired,
    input  logic        wr_req,
    input  logic        rd_req,
    output dram_state_t state
);

    dram_state_t next_state;

    always_comb begin
        next_state = state;
        case (state)
            // init chain
            POWER_UP:      if (expired) next_state = PRE_RESET;
            PRE_RESET:     if (expired) next_state = RESET;
            RESET:         if (expired) next_state = NOP;
            NOP:           if (expired) next_state = LOAD_MODE_DLL;
            LOAD_MODE_DLL: if (expired) next_state = LOAD_BG0_REG3;
            LOAD_BG0_REG3: if (expired) next_state = LOAD_BG1_REG6;
            LOAD_BG1_REG6: if (expired) next_state = LOAD_BG1_REG5;
            LOAD_BG1_REG5: if (expired) next_state = LOAD_BG1_REG4;
            LOAD_BG1_REG4: if (expired) next_state = LOAD_BG0_REG2;
            LOAD_BG0_REG2: if (expired) next_state = LOAD_BG0_REG1;
            LOAD_BG0_REG1: if (expired) next_state = LOAD_BG0_REG0;
            LOAD_BG0_REG0: if (expired) next_state = ZQ_CL;
            ZQ_CL:         if (expired) next_state = IDLE;
            // wait for a request level
            IDLE: begin
                if (wr_req || rd_req) begin
                    next_state = ACTIVATE;
                end
            end
            // write wins when both are held
            ACTIVATE: begin
                if (expired) begin
                    if (wr_req) begin
                        next_state = WRITE_COMMAND;
                    end else if (rd_req) begin
                        next_state = READ_COMMAND;
                    end else begin
                        // request dropped so the row is closed again
                        next_state = PRECHARGE;
                    end
                end
            end
            WRITE_COMMAND: if (expired) next_state = PRECHARGE;
            READ_COMMAND:  if (expired) next_state = PRECHARGE;
            PRECHARGE:     if (expired) next_state = IDLE;
            default:       next_state = POWER_UP;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= POWER_UP;
        end else begin
            state <= next_state;
        end
    end

endmodule

/* dram_command/dram_timer.sv */
/*
 * per-state timing counter
 * rollover value per state from the timing macros
 * expiry flag for the FSM and the encoder
 */
`timescale 1ns/1ps
`include "dram_macros.svh"

module dram_timer
    import dram_state_pkg::*;
(
    input  logic                   CLK,
    input  logic                   nRST,
    input  dram_state_t            state,
    output logic [`DRAM_CNT_W-1:0] timing_count,
    output logic                   expired
);

    logic [`DRAM_CNT_W-1:0] rollover;
    logic [`DRAM_CNT_W-1:0] next_count;

    // how long each state lasts
    always_comb begin
        // idle never expires
        rollover = '1;
        case (state)
            POWER_UP, PRE_RESET, RESET: rollover = `T_PWUP;
            NOP:                        rollover = `T_PDXPR;
            LOAD_MODE_DLL:              rollover = `T_DLLK;
            LOAD_BG0_REG3,
            LOAD_BG1_REG6,
            LOAD_BG1_REG5,
            LOAD_BG1_REG4,
            LOAD_BG0_REG2,
            LOAD_BG0_REG1,
            LOAD_BG0_REG0:              rollover = `T_MOD;
            ZQ_CL:                      rollover = `T_ZQINIT;
            ACTIVATE:                   rollover = `T_RCD;
            WRITE_COMMAND:              rollover = `T_WL + `T_WR + `T_BURST;
            READ_COMMAND:               rollover = `T_CAS + `T_BURST;
            PRECHARGE:                  rollover = `T_RP;
            default:                    rollover = '1;
        endcase
    end

    assign expired = (timing_count == rollover);

    // restart at 1 so the next state sees 1 on entry
    always_comb begin
        next_count = timing_count + 1'b1;
        if (expired || state == IDLE) begin
            next_count = 1;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            // POWER_UP also starts at 1
            timing_count <= 1;
        end else begin
            timing_count <= next_count;
        end
    end

endmodule

/* filelist.f */
+incdir+common
common/dram_state_pkg.sv
common/dram_cmd_pkg.sv
dram_command/dram_timer.sv
dram_command/dram_fsm.sv
dram_command/dram_cmd_encoder.sv
dram_command/dram_command.sv
verification/dram_command_properties.sv
verification/tb_dram_command.sv

/* verification/dram_command_properties.sv */
/*
 * concurrent checks on the sequencer top-level ports
 * one-cycle commands, exclusive data enables
 * single-cycle done pulse, chip deselected while in reset
 */
`timescale 1ns/1ps

module dram_command_properties
    import dram_cmd_pkg::*;
(
    input logic CLK,
    input logic nRST,
    input logic cs_n,
    input logic act_n,
    input logic ras_n_a16,
    input logic cas_n_a15,
    input logic we_n_a14,
    input logic wr_en,
    input logic rd_en,
    input logic request_done,
    input logic reset_n
);

    logic [CMD_W-1:0] cmd_pins;

    assign cmd_pins = {cs_n, act_n, ras_n_a16, cas_n_a15, we_n_a14};

    // every command is a one-cycle strobe
    one_cycle_cmd: assert property (
        @(posedge CLK) disable iff (!nRST)
        (cmd_pins != DESEL_CMD) |=> (cmd_pins == DESEL_CMD)
    ) else $error("command held on the pins for two cycles");

    // only one data direction at a time
    exclusive_enables: assert property (
        @(posedge CLK) disable iff (!nRST)
        !(wr_en && rd_en)
    ) else $error("wr_en and rd_en high together");

    single_done: assert property (
        @(posedge CLK) disable iff (!nRST)
        request_done |=> !request_done
    ) else $error("request_done high for two cycles");

    // device held in reset sees no chip select
    deselect_in_reset: assert property (
        @(posedge CLK)
        !reset_n |-> cs_n
    ) else $error("cs_n low while reset_n low");

endmodule

/* verification/tb_dram_command.sv */
/*
 * testbench for the DDR4 command sequencer
 * clock, reset and watchdog
 * directed tests for the init sequence, idle, single write and single read
 * twenty pseudo-random requests from an xorshift generator
 */
`timescale 1ns/1ps
`include "dram_macros.svh"

module tb_dram_command
    import dram_cmd_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;
    localparam int IDLE_CYCLES  = 50;
    // sum of the init chain rollovers
    localparam int INIT_CYCLES  = 3 * `T_PWUP + `T_PDXPR + `T_DLLK + 7 * `T_MOD + `T_ZQINIT;
    localparam int WR_COL       = `T_WL + `T_WR + `T_BURST;
    localparam int RD_COL       = `T_CAS + `T_BURST;
    // request cycle, activate, longer column state, precharge
    localparam int WORST_REQ    = 1 + `T_RCD + (WR_COL > RD_COL ? WR_COL : RD_COL) + `T_RP;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + INIT_CYCLES + IDLE_CYCLES + 40 * WORST_REQ;
    localparam logic [3:0] LEVELS_ON = 4'b1111;

    logic                    CLK;
    logic                    nRST;
    logic                    wr_req;
    logic                    rd_req;
    logic [`DRAM_BG_W-1:0]   bg;
    logic [`DRAM_BA_W-1:0]   ba;
    logic [`DRAM_ROW_W-1:0]  row;
    logic [`DRAM_COL_W-1:0]  col;
    logic                    request_done;
    logic                    wr_en;
    logic                    rd_en;
    logic                    cs_n;
    logic                    act_n;
    logic                    ras_n_a16;
    logic                    cas_n_a15;
    logic                    we_n_a14;
    logic [`DRAM_BG_W-1:0]   ram_bg;
    logic [`DRAM_BA_W-1:0]   ram_ba;
    logic [`DRAM_ADDR_W-1:0] ram_addr;
    logic                    cke;
    logic                    reset_n;
    logic                    pwr;
    logic                    vref;
    logic [31:0]             rng;

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    dram_command i_dram_command (.*);

    bind dram_command dram_command_properties i_properties (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // command pins in opcode order
    function automatic logic [CMD_W-1:0] cmd_pins();
        return {cs_n, act_n, ras_n_a16, cas_n_a15, we_n_a14};
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERROR %s: %s expected 0x%0h actual 0x%0h", test, what, expected, actual);
            $display("** FAIL **");
            $fatal(1, "%s: wrong %s", test, what);
        end
    endtask

    // one init state shows its command on the first cycle and deselect after
    // levels are {reset_n, cke, pwr, vref}
    task automatic expect_segment(input string name, input int cycles,
                                  input logic [CMD_W-1:0] cmd, input logic [1:0] exp_bg,
                                  input logic [1:0] exp_ba, input logic [13:0] exp_addr,
                                  input logic [3:0] levels);
        for (int c = 0; c < cycles; c++) begin
            @(negedge CLK);
            check_value(name, "control levels", levels, {reset_n, cke, pwr, vref});
            check_value(name, "wr_en, rd_en, done", 3'b000, {wr_en, rd_en, request_done});
            if (c == 0) begin
                check_value(name, "command pins", cmd, cmd_pins());
                check_value(name, "ram_bg", exp_bg, ram_bg);
                check_value(name, "ram_ba", exp_ba, ram_ba);
                check_value(name, "ram_addr", exp_addr, ram_addr);
            end else begin
                check_value(name, "command pins", DESEL_CMD, cmd_pins());
            end
        end
    endtask

    task automatic init_sequence();
        expect_segment("init_sequence POWER_UP", `T_PWUP, POWER_UP_PRG, 0, 0, 0, 4'b0000);
        // supplies up while the device stays in reset
        expect_segment("init_sequence PRE_RESET", `T_PWUP, POWER_UP_PRG, 0, 0, 0, 4'b0011);
        expect_segment("init_sequence RESET", `T_PWUP, POWER_UP_PRG, 0, 0, 0, 4'b1011);
        expect_segment("init_sequence NOP", `T_PDXPR, DESEL_CMD, 0, 0, 0, LEVELS_ON);
        // DLL enable, then the seven loads in table order
        expect_segment("init_sequence MR_DLL", `T_DLLK, LOAD_MODE_CMD,
                       `MR_DLL_BG, `MR_DLL_BA, `MR_DLL_ADDR, LEVELS_ON);
        expect_segment("init_sequence MR3", `T_MOD, LOAD_MODE_CMD,
                       `MR3_BG, `MR3_BA, `MR3_ADDR, LEVELS_ON);
        expect_segment("init_sequence MR6", `T_MOD, LOAD_MODE_CMD,
                       `MR6_BG, `MR6_BA, `MR6_ADDR, LEVELS_ON);
        expect_segment("init_sequence MR5", `T_MOD, LOAD_MODE_CMD,
                       `MR5_BG, `MR5_BA, `MR5_ADDR, LEVELS_ON);
        expect_segment("init_sequence MR4", `T_MOD, LOAD_MODE_CMD,
                       `MR4_BG, `MR4_BA, `MR4_ADDR, LEVELS_ON);
        expect_segment("init_sequence MR2", `T_MOD, LOAD_MODE_CMD,
                       `MR2_BG, `MR2_BA, `MR2_ADDR, LEVELS_ON);
        expect_segment("init_sequence MR1", `T_MOD, LOAD_MODE_CMD,
                       `MR1_BG, `MR1_BA, `MR1_ADDR, LEVELS_ON);
        expect_segment("init_sequence MR0", `T_MOD, LOAD_MODE_CMD,
                       `MR0_BG, `MR0_BA, `MR0_ADDR, LEVELS_ON);
        expect_segment("init_sequence ZQCL", `T_ZQINIT, ZQ_CMD, 0, 0, `ZQ_ADDR, LEVELS_ON);
    endtask

    task automatic idle_quiet();
        repeat (IDLE_CYCLES) begin
            @(negedge CLK);
            check_value("idle_quiet", "command pins", DESEL_CMD, cmd_pins());
            check_value("idle_quiet", "wr_en, rd_en, done", 3'b000, {wr_en, rd_en, request_done});
        end
    endtask

    // index 0 is the cycle the request is raised in IDLE
    task automatic run_request(input string test, input logic is_write,
                               input logic [1:0] r_bg, input logic [1:0] r_ba,
                               input logic [16:0] r_row, input logic [9:0] r_col);
        int               col_k;
        int               en_first;
        int               done_k;
        logic [CMD_W-1:0] exp_cmd;
        logic [13:0]      col_addr;
        col_k    = 1 + `T_RCD;
        en_first = col_k + (is_write ? `T_WL : `T_CAS);
        done_k   = col_k - 1 + (is_write ? WR_COL : RD_COL);
        // A12 high for no burst chop, A10 low for no auto-precharge
        col_addr = {4'b0100, r_col};
        @(posedge CLK);
        #1;
        wr_req = is_write;
        rd_req = !is_write;
        bg     = r_bg;
        ba     = r_ba;
        row    = r_row;
        col    = r_col;
        for (int k = 0; k <= done_k + `T_RP; k++) begin
            @(negedge CLK);
            exp_cmd = DESEL_CMD;
            if (k == 1) begin
                // row bits 16..14 ride on ras/cas/we
                exp_cmd = {2'b00, r_row[16:14]};
            end else if (k == col_k) begin
                exp_cmd = is_write ? WRITE_CMD : READ_CMD;
            end else if (k == done_k + 1) begin
                exp_cmd = PRECHARGE_CMD;
            end
            check_value(test, "command pins", exp_cmd, cmd_pins());
            if (k == 1 || (k >= col_k && k <= done_k + 1)) begin
                check_value(test, "ram_bg", r_bg, ram_bg);
                check_value(test, "ram_ba", r_ba, ram_ba);
            end
            if (k == 1) begin
                check_value(test, "activate row address", r_row[13:0], ram_addr);
            end
            if (k >= col_k && k <= done_k) begin
                check_value(test, "column address", col_addr, ram_addr);
            end
            if (k == done_k + 1) begin
                check_value(test, "precharge A10", 1'b0, ram_addr[10]);
            end
            check_value(test, "wr_en",
                        is_write && k >= en_first && k < en_first + `T_BURST, wr_en);
            check_value(test, "rd_en",
                        !is_write && k >= en_first && k < en_first + `T_BURST, rd_en);
            check_value(test, "request_done", k == done_k, request_done);
            // release the request level after the done pulse
            if (k == done_k) begin
                @(posedge CLK);
                #1;
                wr_req = 1'b0;
                rd_req = 1'b0;
            end
        end
    endtask

    task automatic single_write();
        run_request("single_write", 1'b1, 2'd2, 2'd1, 17'h1A5C3, 10'h2B7);
    endtask

    task automatic single_read();
        run_request("single_read", 1'b0, 2'd1, 2'd3, 17'h0F00F, 10'h155);
    endtask

    task automatic random_requests();
        logic [31:0] r;
        for (int i = 0; i < 20; i++) begin
            rng = xorshift(rng);
            r   = rng;
            rng = xorshift(rng);
            run_request("random_requests", r[0], r[2:1], r[4:3], r[21:5], rng[9:0]);
        end
    endtask

    initial begin
        nRST   = 1'b0;
        wr_req = 1'b0;
        rd_req = 1'b0;
        bg     = '0;
        ba     = '0;
        row    = '0;
        col    = '0;
        rng    = 32'h4866;
        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        nRST = 1'b1;
        init_sequence();
        idle_quiet();
        single_write();
        single_read();
        random_requests();
        $display("** PASS **");
        $finish;
    end

    // init plus a generous number of worst-case requests
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $fatal(1, "timeout");
    end

endmodule
